/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_fpm
FILELIST := vlog.f
PASS_MSG := test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* design/booth_accum.sv */
`timescale 1ns/10ps

module booth_accum (
  input  logic              clk,
  input  logic              rst_n,
  fpm_seq_if.datapath       seq,
  input  fpm_pkg::fp_word_t fp_x,
  input  fpm_pkg::fp_word_t fp_y,
  output fpm_pkg::prod_t    product
);
  import fpm_pkg::*;

  sig_t                              sig_x_in;
  sig_t                              sig_y_in;
  sig_t                              sig_y;    // multiplicand
  logic [$bits(sig_t)+1:0]           y3;       // 3Y, built once
  logic [DIGITS*DIGIT_W:0]           mplr;     // multiplier window, extra low bit
  logic [3:0]                        win;
  logic [2:0]                        mag;
  logic [DIGITS*DIGIT_W-1:0]         mult;
  logic signed [DIGITS*DIGIT_W-1:0]  pp;
  logic signed [2*DIGITS*DIGIT_W+1:0] pp_al;
  logic signed [2*DIGITS*DIGIT_W+1:0] acc_sum;
  logic signed [2*DIGITS*DIGIT_W+1:0] acc;

  assign sig_x_in = {1'b1, fp_x[22:0]};
  assign sig_y_in = {1'b1, fp_y[22:0]};

  always_ff @(posedge clk) begin
    if (seq.load) begin
      sig_y <= sig_y_in;
      y3    <= {2'b00, sig_y_in} + {1'b0, sig_y_in, 1'b0};
      mplr  <= {3'b000, sig_x_in, 1'b0};
    end else if (seq.step) begin
      mplr  <= mplr >> DIGIT_W;
    end
  end

  assign win = mplr[3:0];

  // digit = -4*w3 + 2*w2 + w1 + w0
  always_comb begin
    case (win)
      4'b0000, 4'b1111:                   mag = 3'd0;
      4'b0001, 4'b0010, 4'b1101, 4'b1110: mag = 3'd1;
      4'b0011, 4'b0100, 4'b1011, 4'b1100: mag = 3'd2;
      4'b0101, 4'b0110, 4'b1001, 4'b1010: mag = 3'd3;
      default:                            mag = 3'd4;  // 0111 and 1000
    endcase
  end

  always_comb begin
    case (mag)
      3'd1:    mult = {3'b000, sig_y};
      3'd2:    mult = {2'b00, sig_y, 1'b0};
      3'd3:    mult = {1'b0, y3};
      3'd4:    mult = {1'b0, sig_y, 2'b00};
      default: mult = '0;
    endcase
  end

  assign pp    = win[3] ? -$signed(mult) : $signed(mult);
  assign pp_al = {{(DIGITS*DIGIT_W+2){pp[DIGITS*DIGIT_W-1]}}, pp};

  // add at the top, shift down 3 per digit; digit i ends at bit 3*i
  assign acc_sum = acc + (pp_al <<< (DIGITS * DIGIT_W));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (seq.load) begin
      acc <= '0;
    end else if (seq.step) begin
      acc <= acc_sum >>> DIGIT_W;
    end
  end

  assign product = acc[$bits(prod_t)-1:0];

  // unsigned 48-bit product once all nine digits are in
  assert property (@(posedge clk) disable iff (!rst_n)
    seq.capture |-> acc[$left(acc):$bits(prod_t)] == '0);

endmodule

/* design/digit_counter.sv */
`timescale 1ns/10ps

module digit_counter (
  input  logic       clk,
  input  logic       rst_n,
  fpm_seq_if.counter seq
);
  import fpm_pkg::*;

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (seq.load) begin
      cnt <= '0;
    end else if (seq.step) begin
      cnt <= cnt + 1'b1;
    end
  end

  assign seq.last = seq.step && (cnt == CNT_W'(DIGITS - 1));

  // no stray digit once the product is complete
  assert property (@(posedge clk) disable iff (!rst_n)
    seq.step |-> cnt < CNT_W'(DIGITS));

endmodule

/* design/exp_exc.sv */
`timescale 1ns/10ps

module exp_exc (
  input  logic              clk,
  input  logic              rst_n,
  fpm_seq_if.datapath       seq,
  input  fpm_pkg::fp_word_t fp_x,
  input  fpm_pkg::fp_word_t fp_y,
  input  logic              norm_total,
  input  fpm_pkg::frc_t     frc_z,
  output logic              sign_z,
  output fpm_pkg::fp_word_t fp_z,
  output logic              ovrf,
  output logic              udrf
);
  import fpm_pkg::*;

  logic       sign_x;
  logic       sign_y;
  exp_t       exp_x;
  exp_t       exp_y;
  frc_t       frc_x;
  frc_t       frc_y;
  logic [8:0] exp_sum;
  exp_t       bias;
  exp_t       exp_z;
  logic       ovrf_c;
  logic       udrf_c;
  logic       nan_x, nan_y;
  logic       inf_x, inf_y;
  logic       zer_x, zer_y;
  logic       is_nan, is_inf, is_zer;

  always_ff @(posedge clk) begin
    if (seq.load) begin
      {sign_x, exp_x, frc_x} <= fp_x;
      {sign_y, exp_y, frc_y} <= fp_y;
    end
  end

  assign sign_z = sign_x ^ sign_y;

  // one less bias when the product landed in [2,4)
  assign exp_sum = {1'b0, exp_x} + {1'b0, exp_y};
  assign bias    = norm_total ? BIAS - 8'd1 : BIAS;
  assign exp_z   = exp_sum[7:0] - bias;

  assign ovrf_c = {1'b0, exp_sum} >= ({2'b00, EXP_MAX} + {2'b00, bias});
  assign udrf_c = exp_sum <= {1'b0, bias};

  assign nan_x = (&exp_x) & (|frc_x);
  assign nan_y = (&exp_y) & (|frc_y);
  assign inf_x = (&exp_x) & ~(|frc_x);
  assign inf_y = (&exp_y) & ~(|frc_y);
  assign zer_x = ~(|exp_x);  // denormals flush here too
  assign zer_y = ~(|exp_y);

  assign is_nan = nan_x | nan_y | (&exp_x & zer_y) | (&exp_y & zer_x);  // inf * 0
  assign is_inf = inf_x | inf_y | ovrf_c;
  assign is_zer = zer_x | zer_y | udrf_c;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fp_z <= '0;
      ovrf <= 1'b0;
      udrf <= 1'b0;
    end else if (seq.capture) begin
      ovrf <= ovrf_c;
      udrf <= udrf_c;
      if (is_nan) begin
        fp_z <= QNAN;
      end else if (is_inf) begin
        fp_z <= {sign_z, EXP_MAX, frc_t'(0)};
      end else if (is_zer) begin
        fp_z <= {sign_z, exp_t'(0), frc_t'(0)};
      end else begin
        fp_z <= {sign_z, exp_z, frc_z};
      end
    end
  end

endmodule

/* design/fp_mul_top.sv */
`timescale 1ns/10ps

module fp_mul_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  output logic              in_ready,
  input  fpm_pkg::fp_word_t fp_x,
  input  fpm_pkg::fp_word_t fp_y,
  input  fpm_pkg::rmode_e   r_mode,
  output logic              out_valid,
  input  logic              out_ready,
  output fpm_pkg::fp_word_t fp_z,
  output logic              ovrf,
  output logic              udrf
);
  import fpm_pkg::*;

  prod_t product;   // raw significand product
  frc_t  frc_z;
  logic  sign_z;
  logic  norm_total;

  fpm_seq_if seq ();

  fpm_ctrl fpm_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .seq       (seq.ctrl)
  );

  digit_counter digit_counter (
    .clk   (clk),
    .rst_n (rst_n),
    .seq   (seq.counter)
  );

  booth_accum booth_accum (
    .clk     (clk),
    .rst_n   (rst_n),
    .seq     (seq.datapath),
    .fp_x    (fp_x),
    .fp_y    (fp_y),
    .product (product)
  );

  norm_round norm_round (
    .clk        (clk),
    .rst_n      (rst_n),
    .seq        (seq.datapath),
    .r_mode     (r_mode),
    .sign_z     (sign_z),
    .product    (product),
    .frc_z      (frc_z),
    .norm_total (norm_total)
  );

  exp_exc exp_exc (
    .clk        (clk),
    .rst_n      (rst_n),
    .seq        (seq.datapath),
    .fp_x       (fp_x),
    .fp_y       (fp_y),
    .norm_total (norm_total),
    .frc_z      (frc_z),
    .sign_z     (sign_z),
    .fp_z       (fp_z),
    .ovrf       (ovrf),
    .udrf       (udrf)
  );

endmodule

/* design/fpm_ctrl.sv */
`timescale 1ns/10ps

module fpm_ctrl (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid,
  output logic    in_ready,
  input  logic    out_ready,
  output logic    out_valid,
  fpm_seq_if.ctrl seq
);
  import fpm_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_nxt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (in_valid) state_nxt = RUN;
      end
      RUN: begin
        if (seq.last) state_nxt = FINISH;
      end
      FINISH: state_nxt = HOLD;
      HOLD: begin
        if (out_ready) state_nxt = IDLE;  // result taken
      end
      default: state_nxt = IDLE;
    endcase
  end

  assign in_ready  = (state == IDLE);
  assign out_valid = (state == HOLD);

  assign seq.load    = in_valid && in_ready;
  assign seq.step    = (state == RUN);
  assign seq.capture = (state == FINISH);

  // nine digit steps between load and capture
  assert property (@(posedge clk) disable iff (!rst_n)
    seq.capture |-> $past(seq.load, DIGITS + 1));

endmodule

/* design/fpm_pkg.sv */
package fpm_pkg;

  // ieee single fields
  typedef logic [31:0] fp_word_t;
  typedef logic [22:0] frc_t;
  typedef logic [23:0] sig_t;   // hidden bit on top
  typedef logic [7:0]  exp_t;

  typedef logic [47:0] prod_t;
  typedef logic [26:0] rnd_sig_t;  // 24 bits + guard, round, sticky

  typedef enum logic [2:0] {
    RNE = 3'd0,  // nearest, ties to even
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4   // nearest, ties away
  } rmode_e;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FINISH,
    HOLD
  } ctrl_state_e;

  localparam exp_t BIAS = 8'd127;

  // radix-8 booth, 3 multiplier bits per digit
  localparam int DIGITS  = 9;
  localparam int DIGIT_W = 3;
  localparam int CNT_W   = 4;

  localparam fp_word_t QNAN    = 32'h7fc0_0000;
  localparam exp_t     EXP_MAX = 8'd255;

endpackage

/* design/fpm_seq_if.sv */
`timescale 1ns/10ps

interface fpm_seq_if;

  logic load;     // operand acceptance
  logic step;     // one booth digit per cycle
  logic last;     // ninth digit
  logic capture;  // register packed result

  modport ctrl (
    output load,
    output step,
    output capture,
    input  last
  );

  modport counter (
    input  load,
    input  step,
    output last
  );

  modport datapath (
    input load,
    input step,
    input capture
  );

endinterface

/* design/norm_round.sv */
`timescale 1ns/10ps

module norm_round (
  input  logic            clk,
  input  logic            rst_n,
  fpm_seq_if.datapath     seq,
  input  fpm_pkg::rmode_e r_mode,
  input  logic            sign_z,
  input  fpm_pkg::prod_t  product,
  output fpm_pkg::frc_t   frc_z,
  output logic            norm_total
);
  import fpm_pkg::*;

  rmode_e                mode_q;
  prod_t                 shifted;
  rnd_sig_t              sig_n;
  logic                  grd;
  logic                  rnd;
  logic                  stk;
  logic                  inexact;
  logic [$bits(sig_t):0] trunc;
  logic [$bits(sig_t):0] plus;
  logic [$bits(sig_t):0] rounded;
  logic                  carry;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode_q <= RNE;
    end else if (seq.load) begin
      mode_q <= r_mode;
    end
  end

  // product in [1,4), bring leading one to bit 47
  assign shifted = product[47] ? product : {product[46:0], 1'b0};
  assign sig_n   = {shifted[47:22], |shifted[21:0]};

  assign grd = sig_n[2];
  assign rnd = sig_n[1];
  assign stk = sig_n[0];

  assign inexact = grd | rnd | stk;

  assign trunc = {1'b0, sig_n[26:3]};
  assign plus  = trunc + 1'b1;

  always_comb begin
    case (mode_q)
      RNE: begin
        if (!grd) begin
          rounded = trunc;
        end else if (rnd || stk || sig_n[3]) begin
          rounded = plus;  // above half, or tie with odd lsb
        end else begin
          rounded = trunc;
        end
      end
      RTZ:     rounded = trunc;
      RDN:     rounded = (sign_z && inexact) ? plus : trunc;
      RUP:     rounded = (!sign_z && inexact) ? plus : trunc;
      default: rounded = grd ? plus : trunc;  // ties away
    endcase
  end

  // 1.111..1 + ulp overflows to 10.000..0
  assign carry = rounded[$bits(sig_t)];
  assign frc_z = carry ? rounded[23:1] : rounded[22:0];

  assign norm_total = product[47] | carry;

endmodule

/* tb/fpm_stimulus.txt */
# fp_x fp_y mode fp_z ovrf udrf name, words in hex, flags 0 or 1
# mode 0 nearest-even, 1 toward zero, 2 down, 3 up, 4 nearest-max
3f800000 3f800000 0 3f800000 0 0 one_rne
3fc00000 3fc00000 1 40100000 0 0 sq15_rtz
40000000 40400000 0 40c00000 0 0 six_rne
c0000000 40400000 0 c0c00000 0 0 negsix_rne
40400000 40a00000 0 41700000 0 0 fifteen_rne
bfc00000 bfc00000 4 40100000 0 0 negsq_rmm
3f800001 3f800001 0 3f800002 0 0 inexact_rne
3f800001 3f800001 2 3f800002 0 0 inexact_rdn
3f800001 3f800001 3 3f800003 0 0 inexact_rup
bf800001 3f800001 2 bf800003 0 0 neg_inexact_rdn
bf800001 3f800001 3 bf800002 0 0 neg_inexact_rup
3fc00000 3f800001 0 3fc00002 0 0 tie_odd_rne
3fc00000 3f800001 1 3fc00001 0 0 tie_odd_rtz
3fc00000 3f800001 4 3fc00002 0 0 tie_odd_rmm
3fc00000 3f800003 0 3fc00004 0 0 tie_even_rne
3fc00000 3f800003 4 3fc00005 0 0 tie_even_rmm
3fffffff 3f800001 0 40000000 0 0 top_rne
3fffffff 3f800001 3 40000001 0 0 top_rup
7fc00000 3f000000 0 7fc00000 0 0 nan_op
7f800000 00000000 0 7fc00000 0 0 inf_zero
ff800000 3f000000 0 ff800000 0 0 inf_neg
00000000 40400000 0 00000000 0 0 zero_pos
00400000 c0000000 0 80000000 0 0 denorm_neg
00000000 3f800000 0 00000000 0 1 zero_udrf
1f800000 1f800000 0 00000000 0 1 udrf_small
9f800000 20000000 0 80000000 0 1 udrf_edge
20000000 20000000 0 00800000 0 0 min_normal
5f800000 5f000000 0 7f000000 0 0 big_ok
5f800000 5f800000 0 7f800000 1 0 ovrf_big
dfc00000 5f400000 0 ff800000 1 0 ovrf_p47

/* tb/tb_fpm.sv */
`timescale 1ns/10ps

module tb_fpm;
  import fpm_pkg::*;

  localparam int MAX_VEC   = 64;
  localparam int MAX_STALL = 6;
  localparam int LATENCY   = 11;  // accepting edge to out_valid

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  logic     in_ready;
  fp_word_t fp_x;
  fp_word_t fp_y;
  rmode_e   r_mode;
  logic     out_valid;
  logic     out_ready;
  fp_word_t fp_z;
  logic     ovrf;
  logic     udrf;

  logic [31:0] vx [MAX_VEC];
  logic [31:0] vy [MAX_VEC];
  logic [31:0] vz [MAX_VEC];
  int          vm [MAX_VEC];
  int          vo [MAX_VEC];
  int          vu [MAX_VEC];
  string       names [MAX_VEC];
  int          n_vec = 0;
  int          cycles = 0;
  int          limit = 1000;

  fp_mul_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .fp_x      (fp_x),
    .fp_y      (fp_y),
    .r_mode    (r_mode),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .fp_z      (fp_z),
    .ovrf      (ovrf),
    .udrf      (udrf)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: no result after %0d cycles, the DUT seems to hang", cycles);
      $display("test failed");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic read_vectors();
    int    fd;
    int    cnt;
    string line;
    string nm;
    fd = $fopen("tb/fpm_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file tb/fpm_stimulus.txt");
      $display("test failed");
      $fatal(1);
    end
    while (!$feof(fd) && n_vec < MAX_VEC) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line.getc(0) == "#") continue;  // header or blank
      cnt = $sscanf(line, "%h %h %d %h %d %d %s", vx[n_vec], vy[n_vec], vm[n_vec],
                    vz[n_vec], vo[n_vec], vu[n_vec], nm);
      if (cnt != 7) begin
        $display("malformed stimulus line: %s", line);
        $display("test failed");
        $fatal(1);
      end
      names[n_vec] = nm;
      n_vec++;
    end
    $fclose(fd);
    limit = n_vec * (12 + MAX_STALL) + 50;
  endtask

  task automatic check_result(input int i);
    check_value({names[i], " fp_z"}, vz[i], fp_z);
    check_value({names[i], " ovrf"}, vo[i], 32'(ovrf));
    check_value({names[i], " udrf"}, vu[i], 32'(udrf));
    check_value({names[i], " in_ready"}, 32'd0, 32'(in_ready));
  endtask

  task automatic run_vector(input int i);
    int lat;
    int stall;
    int held;
    fp_x     <= vx[i];
    fp_y     <= vy[i];
    r_mode   <= rmode_e'(vm[i][2:0]);
    in_valid <= 1'b1;
    @(posedge clk);
    // free again one cycle after the previous output handshake
    check_value({names[i], " in_ready at accept"}, 32'd1, 32'(in_ready));
    check_value({names[i], " out_valid at accept"}, 32'd0, 32'(out_valid));
    in_valid  <= 1'b0;
    stall     = $urandom % (MAX_STALL + 1);
    out_ready <= (stall == 0);  // zero stall takes the result at once
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      if (!out_valid) check_value({names[i], " busy in_ready"}, 32'd0, 32'(in_ready));
    end while (!out_valid && lat < 2 * LATENCY);
    check_value({names[i], " latency"}, LATENCY, 32'(lat));
    check_result(i);
    held = 0;
    while (!out_ready) begin
      held++;
      if (held >= stall) out_ready <= 1'b1;
      @(posedge clk);
      check_value({names[i], " out_valid held"}, 32'd1, 32'(out_valid));
      check_result(i);  // must not move while stalled
    end
    out_ready <= 1'b0;
  endtask

  initial begin
    void'($urandom(55));
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    fp_x      = '0;
    fp_y      = '0;
    r_mode    = RNE;
    read_vectors();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("reset in_ready", 32'd1, 32'(in_ready));
    check_value("reset out_valid", 32'd0, 32'(out_valid));
    for (int i = 0; i < n_vec; i++) begin
      run_vector(i);  // next one starts on the handshake edge
    end
    @(posedge clk);
    check_value("final out_valid", 32'd0, 32'(out_valid));  // nothing repeated
    $display("test passed");
    $finish;
  end

endmodule

/* vlog.f */
design/fpm_pkg.sv
design/fpm_seq_if.sv
design/fpm_ctrl.sv
design/digit_counter.sv
design/booth_accum.sv
design/norm_round.sv
design/exp_exc.sv
design/fp_mul_top.sv
tb/tb_fpm.sv
